// ==== verilog/div_defines.svh ====
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

`define DIV_WIDTH      64
`define APB_ADDR_WIDTH 5

// register map, byte offsets.
`define REG_DVD_LO 5'h00
`define REG_DVD_HI 5'h04
`define REG_DVR_LO 5'h08
`define REG_DVR_HI 5'h0C
`define REG_CTRL   5'h10
`define REG_STATUS 5'h14
`define REG_RES_LO 5'h18
`define REG_RES_HI 5'h1C

`define CTRL_START  0
`define CTRL_SIGNED 1
`define CTRL_REM    2
`define CTRL_FLUSH  3

`define STAT_BUSY 0
`define STAT_DONE 1

`endif

// ==== verilog/div_pkg.sv ====
`default_nettype none

`include "div_defines.svh"

package div_pkg;

  typedef struct packed {
    logic [`DIV_WIDTH-1:0] dividend;
    logic [`DIV_WIDTH-1:0] divisor;
    logic                  is_signed;  // two's complement operands.
    logic                  want_rem;   // return remainder instead of quotient.
  } div_req_t;

  typedef struct packed {
    logic [`DIV_WIDTH-1:0] value;
  } div_result_t;

  // sequencer states.
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    LOAD = 2'd1,
    ITER = 2'd2,
    FIX  = 2'd3
  } div_state_e;

endpackage

`default_nettype wire

// ==== verilog/cla_adder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module cla_adder #(
  parameter int width = `DIV_WIDTH  // multiple of four.
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  logic             cin,
  output logic [width-1:0] sum
);

  localparam int groups = width / 4;

  logic [width-1:0]  g;
  logic [width-1:0]  p;
  logic [width-1:0]  c;
  logic [groups-1:0] gc;  // carry into each group.

  assign g     = a & b;
  assign p     = a ^ b;
  assign gc[0] = cin;

  for (genvar i = 0; i < groups; i++) begin : g_grp
    localparam int lo = 4 * i;

    // lookahead inside the group.
    assign c[lo]   = gc[i];
    assign c[lo+1] = g[lo] | (p[lo] & gc[i]);
    assign c[lo+2] = g[lo+1] | (p[lo+1] & g[lo]) | (p[lo+1] & p[lo] & gc[i]);
    assign c[lo+3] = g[lo+2] | (p[lo+2] & g[lo+1]) | (p[lo+2] & p[lo+1] & g[lo])
                   | (p[lo+2] & p[lo+1] & p[lo] & gc[i]);

    if (i < groups - 1) begin : g_chain
      logic grp_g;
      logic grp_p;

      assign grp_g = g[lo+3] | (p[lo+3] & g[lo+2]) | (p[lo+3] & p[lo+2] & g[lo+1])
                   | (p[lo+3] & p[lo+2] & p[lo+1] & g[lo]);
      assign grp_p = &p[lo+3:lo];
      assign gc[i+1] = grp_g | (grp_p & gc[i]);  // second level.
    end
  end

  assign sum = p ^ c;

endmodule

`default_nettype wire

// ==== verilog/div_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_apb_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_ADDR_WIDTH-1:0] paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  output div_pkg::div_req_t          req,
  output logic                       start,
  output logic                       flush,
  input  logic                       busy,
  input  logic                       done,
  input  div_pkg::div_result_t       result
);

  logic [`DIV_WIDTH-1:0] dvd_q;
  logic [`DIV_WIDTH-1:0] dvr_q;
  logic                  signed_q;
  logic                  rem_q;
  logic                  done_q;
  logic                  wr_en;
  logic                  ctrl_wr;

  assign pready  = 1'b1;  // every transfer ends in its access phase.
  assign pslverr = 1'b0;

  assign wr_en   = psel & penable & pwrite;
  assign ctrl_wr = wr_en & (paddr == `REG_CTRL);

  // flush beats start when both bits come in one write.
  assign start = ctrl_wr & pwdata[`CTRL_START] & ~pwdata[`CTRL_FLUSH];
  assign flush = ctrl_wr & pwdata[`CTRL_FLUSH];

  // ################################################
  // operand and control registers
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (paddr)
        `REG_DVD_LO: dvd_q[31:0]            <= pwdata;
        `REG_DVD_HI: dvd_q[`DIV_WIDTH-1:32] <= pwdata;
        `REG_DVR_LO: dvr_q[31:0]            <= pwdata;
        `REG_DVR_HI: dvr_q[`DIV_WIDTH-1:32] <= pwdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      signed_q <= 1'b0;
      rem_q    <= 1'b0;
    end else if (start && !busy) begin  // a dropped start keeps the old mode.
      signed_q <= pwdata[`CTRL_SIGNED];
      rem_q    <= pwdata[`CTRL_REM];
    end
  end

  // sticky done.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (start || flush) begin
      done_q <= 1'b0;
    end else if (done) begin
      done_q <= 1'b1;
    end
  end

  assign req.dividend  = dvd_q;
  assign req.divisor   = dvr_q;
  assign req.is_signed = signed_q;
  assign req.want_rem  = rem_q;

  // ################################################
  // read mux
  always_comb begin
    prdata = 32'b0;
    case (paddr)
      `REG_DVD_LO: prdata = dvd_q[31:0];
      `REG_DVD_HI: prdata = dvd_q[`DIV_WIDTH-1:32];
      `REG_DVR_LO: prdata = dvr_q[31:0];
      `REG_DVR_HI: prdata = dvr_q[`DIV_WIDTH-1:32];
      `REG_CTRL: begin
        prdata[`CTRL_SIGNED] = signed_q;
        prdata[`CTRL_REM]    = rem_q;
      end
      `REG_STATUS: begin
        prdata[`STAT_BUSY] = busy;
        prdata[`STAT_DONE] = done_q | done;  // pulse shows in its own cycle.
      end
      `REG_RES_LO: prdata = result.value[31:0];
      `REG_RES_HI: prdata = result.value[`DIV_WIDTH-1:32];
      default: prdata = 32'b0;
    endcase
  end

  // status never shows busy and done together.
  a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !(done_q || done))
    else $error("done shown while busy.");

endmodule

`default_nettype wire

// ==== verilog/div_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic flush,
  input  logic last,
  output logic load,
  output logic step,
  output logic finish,
  output logic busy,
  output logic done
);

  div_pkg::div_state_e state_q;
  div_pkg::div_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      div_pkg::IDLE: if (start) state_d = div_pkg::LOAD;
      div_pkg::LOAD: state_d = div_pkg::ITER;
      div_pkg::ITER: if (last) state_d = div_pkg::FIX;  // last step taken.
      div_pkg::FIX:  state_d = div_pkg::IDLE;
      default:       state_d = div_pkg::IDLE;
    endcase
    if (flush) begin
      state_d = div_pkg::IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= div_pkg::IDLE;
      done    <= 1'b0;
    end else begin
      state_q <= state_d;
      done    <= finish & ~flush;  // flushed fix-up gives no done.
    end
  end

  assign load   = (state_q == div_pkg::LOAD);
  assign step   = (state_q == div_pkg::ITER);
  assign finish = (state_q == div_pkg::FIX);
  assign busy   = (state_q != div_pkg::IDLE);

  // ################################################
  // sequencing checks
  // the counter ends a run after one step per result bit.
  a_iter_length: assert property (@(posedge clk) disable iff (!rst_n)
    (step && last) |-> $past(step, `DIV_WIDTH - 1))
    else $error("iteration run has the wrong number of steps.");

endmodule

`default_nettype wire

// ==== verilog/div_step_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_step_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic step,
  output logic last
);

  localparam int cnt_w = $clog2(`DIV_WIDTH);

  logic [cnt_w-1:0] count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= cnt_w'(`DIV_WIDTH - 1);
    end else if (step && count_q != '0) begin
      count_q <= count_q - 1'b1;  // holds at zero.
    end
  end

  assign last = (count_q == '0);

  // the sequencer must stop stepping once the last step is taken.
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    (step && last) |=> !step)
    else $error("step after the last iteration.");

endmodule

`default_nettype wire

// ==== verilog/div_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_datapath (
  input  logic                 clk,
  input  logic                 rst_n,
  input  div_pkg::div_req_t    req,
  input  logic                 load,
  input  logic                 step,
  input  logic                 finish,
  input  logic                 flush,
  output div_pkg::div_result_t result
);

  localparam int w  = `DIV_WIDTH;
  localparam int aw = `DIV_WIDTH + 4;  // sign and carry headroom.

  logic [aw-1:0] p_q;         // partial remainder.
  logic [w-1:0]  q_q;         // dividend out at the top, quotient in at the bottom.
  logic [aw-1:0] dvr_pos_q;
  logic [aw-1:0] dvr_neg_q;
  logic [w-1:0]  dvd_orig_q;
  logic          q_neg_q;
  logic          r_neg_q;
  logic          want_rem_q;
  logic          zero_q;
  logic          ovf_q;

  logic          dvd_neg;
  logic          dvr_neg;
  logic [w-1:0]  dvd_mag;
  logic [w-1:0]  dvr_mag;
  logic [aw-1:0] add_a;
  logic [aw-1:0] add_b;
  logic [aw-1:0] add_sum;
  logic [w-1:0]  rem_mag;
  logic [w-1:0]  quo_fix;
  logic [w-1:0]  rem_fix;
  logic [w-1:0]  res_d;

  assign dvd_neg = req.is_signed & req.dividend[w-1];
  assign dvr_neg = req.is_signed & req.divisor[w-1];
  assign dvd_mag = dvd_neg ? (~req.dividend + 1'b1) : req.dividend;
  assign dvr_mag = dvr_neg ? (~req.divisor + 1'b1) : req.divisor;

  // ################################################
  // load and iterate
  always_ff @(posedge clk) begin
    if (load) begin
      p_q        <= '0;
      q_q        <= dvd_mag;
      dvr_pos_q  <= {{(aw-w){1'b0}}, dvr_mag};
      dvr_neg_q  <= ~{{(aw-w){1'b0}}, dvr_mag} + 1'b1;
      dvd_orig_q <= req.dividend;
    end else if (step) begin
      p_q <= add_sum;
      q_q <= {q_q[w-2:0], ~add_sum[aw-1]};  // quotient bit is the new sign, inverted.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_neg_q    <= 1'b0;
      r_neg_q    <= 1'b0;
      want_rem_q <= 1'b0;
      zero_q     <= 1'b0;
      ovf_q      <= 1'b0;
    end else if (flush) begin
      q_neg_q    <= 1'b0;
      r_neg_q    <= 1'b0;
      want_rem_q <= 1'b0;
      zero_q     <= 1'b0;
      ovf_q      <= 1'b0;
    end else if (load) begin
      q_neg_q    <= dvd_neg ^ dvr_neg;
      r_neg_q    <= dvd_neg;
      want_rem_q <= req.want_rem;
      zero_q     <= ~|req.divisor;
      ovf_q      <= req.is_signed && (req.dividend == {1'b1, {(w-1){1'b0}}})
                    && (&req.divisor);
    end
  end

  // subtract while the remainder is positive, add back while negative.
  // in FIX the same adder restores a negative remainder.
  assign add_a = finish ? p_q : {p_q[aw-2:0], q_q[w-1]};
  assign add_b = p_q[aw-1] ? dvr_pos_q : dvr_neg_q;

  cla_adder #(
    .width (aw)
  ) i_cla_adder (
    .a   (add_a),
    .b   (add_b),
    .cin (1'b0),
    .sum (add_sum)
  );

  // ################################################
  // fix-up
  assign rem_mag = p_q[aw-1] ? add_sum[w-1:0] : p_q[w-1:0];

  always_comb begin
    quo_fix = q_neg_q ? (~q_q + 1'b1) : q_q;
    rem_fix = r_neg_q ? (~rem_mag + 1'b1) : rem_mag;
    if (zero_q) begin
      quo_fix = '1;
      rem_fix = dvd_orig_q;
    end else if (ovf_q) begin
      quo_fix = dvd_orig_q;
      rem_fix = '0;
    end
    res_d = want_rem_q ? rem_fix : quo_fix;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result.value <= '0;
    end else if (finish && !flush) begin
      result.value <= res_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/div_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_ADDR_WIDTH-1:0] paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr
);

  div_pkg::div_req_t    req;
  div_pkg::div_result_t result;
  logic                 start;
  logic                 flush;
  logic                 busy;
  logic                 done;
  logic                 load;
  logic                 step;
  logic                 finish;
  logic                 last;

  div_apb_regs i_div_apb_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .req     (req),
    .start   (start),
    .flush   (flush),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  div_fsm i_div_fsm (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .flush  (flush),
    .last   (last),
    .load   (load),
    .step   (step),
    .finish (finish),
    .busy   (busy),
    .done   (done)
  );

  div_step_counter i_div_step_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .step  (step),
    .last  (last)
  );

  div_datapath i_div_datapath (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .load   (load),
    .step   (step),
    .finish (finish),
    .flush  (flush),
    .result (result)
  );

endmodule

`default_nettype wire

// ==== sim/div_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module div_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period.
  end

  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/div_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_tb;

  typedef struct packed {
    logic [63:0] dvd;
    logic [63:0] dvr;
    logic        sgn;
    logic        rem;
    logic [63:0] want;
  } row_t;

  localparam int n_rows          = 18;
  localparam int n_rand          = 8;
  localparam int n_tests         = n_rows + n_rand + 3;
  localparam int watchdog_cycles = n_tests * 100 + 16;

  // truncating division, RISC-V values for divide by zero and overflow.
  row_t rows [n_rows] = '{
    '{64'd100, 64'd7, 1'b0, 1'b0, 64'd14},
    '{64'd100, 64'd7, 1'b0, 1'b1, 64'd2},
    '{64'hFFFF_FFFF_FFFF_FFFF, 64'd3, 1'b0, 1'b0, 64'h5555_5555_5555_5555},
    '{64'hFFFF_FFFF_FFFF_FFF9, 64'd2, 1'b1, 1'b0, 64'hFFFF_FFFF_FFFF_FFFD},  // -7 / 2.
    '{64'hFFFF_FFFF_FFFF_FFF9, 64'd2, 1'b1, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF},
    '{64'd7, 64'hFFFF_FFFF_FFFF_FFFE, 1'b1, 1'b0, 64'hFFFF_FFFF_FFFF_FFFD},  // 7 / -2.
    '{64'd7, 64'hFFFF_FFFF_FFFF_FFFE, 1'b1, 1'b1, 64'd1},
    '{64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFFE, 1'b1, 1'b0, 64'd3},
    '{64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFFE, 1'b1, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF},
    '{64'd7, 64'd2, 1'b1, 1'b0, 64'd3},
    '{64'd1234, 64'd0, 1'b0, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF},
    '{64'd1234, 64'd0, 1'b0, 1'b1, 64'd1234},
    '{64'hFFFF_FFFF_FFFF_FFFB, 64'd0, 1'b1, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF},
    '{64'hFFFF_FFFF_FFFF_FFFB, 64'd0, 1'b1, 1'b1, 64'hFFFF_FFFF_FFFF_FFFB},
    '{64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 1'b0, 64'h8000_0000_0000_0000},
    '{64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 1'b1, 64'd0},
    '{64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, 1'b0, 64'd0},
    '{64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, 1'b1, 64'h8000_0000_0000_0000}
  };

  logic                       clk;
  logic                       rst_n;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`APB_ADDR_WIDTH-1:0] paddr;
  logic [31:0]                pwdata;
  logic [31:0]                prdata;
  logic                       pready;
  logic                       pslverr;
  logic [31:0]                lfsr_q;
  logic                       test_bad = 1'b0;
  int                         cyc = 0;
  int                         wr_cyc;
  int                         rd_cyc;
  int                         start_cyc;
  int                         errors = 0;
  int                         failed = 0;
  int                         tests = 0;

  div_clock_gen i_div_clock_gen (.clk(clk), .rst_n(rst_n));

  div_top i_div_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // ##################################################
  // helpers
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1.
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[31]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  function automatic logic [63:0] model_div(input logic [63:0] a, input logic [63:0] b,
                                            input logic sgn, input logic rem);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = a;
    sb = b;
    if (b == 64'd0) return rem ? a : '1;
    if (sgn && a == 64'h8000_0000_0000_0000 && b == '1) return rem ? 64'd0 : a;
    if (sgn) return rem ? sa % sb : sa / sb;
    return rem ? a % b : a / b;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("** Error: %s is %h, expected %h", name, got, want);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (test_bad) begin
      failed++;
      $display("test %0d %s: FAIL", tests, name);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
    test_bad = 1'b0;
  endtask

  task automatic apb_write(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    wr_cyc = cyc;  // access cycle, the write lands at its closing edge.
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data   = prdata;
    rd_cyc = cyc;
    check_value("pready", pready, 1);
    check_value("pslverr", pslverr, 0);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic start_division(input logic [63:0] dvd, input logic [63:0] dvr,
                                input logic sgn, input logic rem);
    apb_write(`REG_DVD_LO, dvd[31:0]);
    apb_write(`REG_DVD_HI, dvd[63:32]);
    apb_write(`REG_DVR_LO, dvr[31:0]);
    apb_write(`REG_DVR_HI, dvr[63:32]);
    apb_write(`REG_CTRL, {29'b0, rem, sgn, 1'b1});
    start_cyc = wr_cyc + 1;
  endtask

  // busy through cycle 65, done from cycle 66 on.
  task automatic finish_division(output logic [63:0] res);
    logic [31:0] st;
    logic [31:0] lo;
    int          polls;
    st    = 32'h1;
    polls = 0;
    while (st[`STAT_BUSY] && polls < 40) begin
      apb_read(`REG_STATUS, st);
      check_value("status.busy", st[`STAT_BUSY], (rd_cyc - start_cyc) <= 65);
      check_value("status.done", st[`STAT_DONE], (rd_cyc - start_cyc) >= 66);
      polls++;
    end
    if (st[`STAT_BUSY]) begin
      $display("divider still busy after %0d status polls.", polls);
      errors++;
      test_bad = 1'b1;
    end
    apb_read(`REG_RES_LO, lo);
    apb_read(`REG_RES_HI, st);
    res = {st, lo};
  endtask

  // ##################################################
  // watchdog
  initial begin
    #(watchdog_cycles * 10);
    $display("watchdog expired after %0d cycles, the run did not finish.", watchdog_cycles);
    $display("Done: errors found");
    $finish;
  end

  // ##################################################
  // test sequence
  initial begin
    logic [63:0] res;
    logic [63:0] dvd;
    logic [63:0] dvr;
    logic [63:0] sh;
    logic [63:0] mode;
    logic [31:0] rd;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    lfsr_q  = 32'd75206;
    @(posedge rst_n);
    @(posedge clk);

    apb_read(`REG_STATUS, rd);
    check_value("status", rd, 0);
    apb_read(`REG_RES_LO, rd);
    check_value("res_lo", rd, 0);
    apb_read(`REG_RES_HI, rd);
    check_value("res_hi", rd, 0);
    report_test("reset values");

    for (int i = 0; i < n_rows; i++) begin
      start_division(rows[i].dvd, rows[i].dvr, rows[i].sgn, rows[i].rem);
      finish_division(res);
      check_value("result", res, rows[i].want);
      report_test($sformatf("table row %0d", i));
    end

    for (int i = 0; i < n_rand; i++) begin
      draw_bits(64, dvd);
      draw_bits(64, dvr);
      draw_bits(6, sh);
      draw_bits(2, mode);
      dvr = dvr >> sh;  // spread the quotient lengths.
      start_division(dvd, dvr, mode[0], mode[1]);
      finish_division(res);
      check_value("result", res, model_div(dvd, dvr, mode[0], mode[1]));
      report_test($sformatf("random %0d", i));
    end

    // second start while busy asks for the remainder and must be dropped.
    start_division(64'd100, 64'd7, 1'b0, 1'b0);
    apb_write(`REG_CTRL, 32'h5);
    finish_division(res);
    check_value("result", res, 64'd14);
    report_test("start while busy");

    start_division(64'd1000, 64'd10, 1'b0, 1'b0);
    apb_write(`REG_CTRL, 32'h8);
    apb_read(`REG_STATUS, rd);
    check_value("status", rd, 0);
    repeat (70) @(posedge clk);
    apb_read(`REG_STATUS, rd);
    check_value("status", rd, 0);
    apb_read(`REG_RES_LO, rd);
    check_value("res_lo", rd, 14);
    apb_read(`REG_RES_HI, rd);
    check_value("res_hi", rd, 0);
    report_test("flush");

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/div_pkg.sv
verilog/cla_adder.sv
verilog/div_apb_regs.sv
verilog/div_fsm.sv
verilog/div_step_counter.sv
verilog/div_datapath.sv
verilog/div_top.sv
sim/div_clock_gen.sv
sim/div_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divider testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module div_tb -o div_tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/div_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0
